/* src/flash_cmd_pkg.sv */
// --------------------
// flash command package
// frame layout, header bytes, flash opcodes, LED codes
// and the shared types of the command processor
// --------------------
package flash_cmd_pkg;

	// -------------------- frame layout
	localparam int FRAME_BYTES = 12;
	localparam int CNT_W       = $clog2(FRAME_BYTES + 1);   // counter holds 0..12

	typedef logic [7:0]                 byte_t;
	typedef byte_t [FRAME_BYTES-1:0]    frame_t;             // index 0 is the first byte
	typedef logic [23:0]                addr_t;
	typedef logic [4:0]                 cmd_type_t;

	// -------------------- header and control bytes
	localparam byte_t HDR_C   = 8'h43;
	localparam byte_t HDR_M   = 8'h4D;
	localparam byte_t HDR_LEN = 8'h0C;   // frame length
	localparam byte_t HDR_F   = 8'h46;   // flash target
	localparam byte_t REC_R   = 8'h52;
	localparam byte_t REC_S   = 8'h53;
	localparam byte_t CHAR_CR = 8'h0D;
	localparam byte_t CHAR_LF = 8'h0A;

	// -------------------- operation letters
	localparam byte_t GRP_R = 8'h52;   // read
	localparam byte_t GRP_W = 8'h57;   // write / mode
	localparam byte_t GRP_Q = 8'h51;   // quad io
	localparam byte_t GRP_S = 8'h53;   // single io, erase
	localparam byte_t OPL_I = 8'h49;
	localparam byte_t OPL_S = 8'h53;
	localparam byte_t OPL_E = 8'h45;
	localparam byte_t OPL_D = 8'h44;
	localparam byte_t OPL_Q = 8'h51;
	localparam byte_t OPL_O = 8'h4F;
	localparam byte_t OPL_P = 8'h50;
	localparam byte_t OPL_R = 8'h52;

	// -------------------- flash opcodes
	typedef enum logic [7:0] {
		OP_NONE         = 8'h00,
		OP_READ_ID      = 8'h90,
		OP_READ_SR1     = 8'h05,
		OP_READ_SR2     = 8'h35,
		OP_READ_SR3     = 8'h15,
		OP_WR_ENABLE    = 8'h06,
		OP_WR_DISABLE   = 8'h04,
		OP_WR_SR1       = 8'h01,
		OP_WR_SR2       = 8'h31,
		OP_WR_SR3       = 8'h11,
		OP_ENTER_QPI    = 8'h38,
		OP_EXIT_QPI     = 8'hFF,
		OP_QUAD_PROGRAM = 8'h32,
		OP_QUAD_READ    = 8'h6B,
		OP_PAGE_PROGRAM = 8'h02,
		OP_READ         = 8'h03,
		OP_SECTOR_ERASE = 8'h20
	} flash_op_e;

	typedef enum logic [1:0] {RES_ISSUE, RES_RECOVER, RES_INVALID} decode_result_e;

	// -------------------- LED codes
	localparam logic [3:0] LED_RESET   = 4'b1111;
	localparam logic [3:0] LED_BUSY    = 4'b0001;
	localparam logic [3:0] LED_DONE    = 4'b0011;
	localparam logic [3:0] LED_ERROR   = 4'b0000;
	localparam logic [3:0] LED_RECOVER = 4'b1110;

endpackage

/* src/frame_if.sv */
// --------------------
// frame bus
// completed frame from assembler to decoder
// --------------------
`timescale 1ns/1ps

interface frame_if;

	logic                   frame_valid;   // one-cycle pulse, good frame
	logic                   frame_bad;     // one-cycle pulse, length error
	flash_cmd_pkg::frame_t  frame;         // valid with frame_valid

	modport assembler
	(
		output frame_valid,
		output frame_bad,
		output frame
	);

	modport decoder
	(
		input frame_valid,
		input frame_bad,
		input frame
	);

endinterface

/* src/flash_req_if.sv */
// --------------------
// flash request bus
// decoded request from decoder to issuer
// --------------------
`timescale 1ns/1ps

interface flash_req_if;

	logic                            req_valid;   // one-cycle pulse
	flash_cmd_pkg::decode_result_e   result;
	flash_cmd_pkg::flash_op_e        op;
	flash_cmd_pkg::addr_t            addr;
	flash_cmd_pkg::cmd_type_t        cmd_type;

	modport decoder
	(
		output req_valid,
		output result,
		output op,
		output addr,
		output cmd_type
	);

	modport issuer
	(
		input req_valid,
		input result,
		input op,
		input addr,
		input cmd_type
	);

endinterface

/* src/frame_assembler.sv */
// --------------------
// frame assembler
// turns the falling edge of rx_int into a byte strobe and
// collects bytes into a frame ending in CR LF
// --------------------
`timescale 1ns/1ps

module frame_assembler
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   rx_int,    // high while a byte is received
	input  flash_cmd_pkg::byte_t   rx_data,
	frame_if.assembler             fr
);

	logic [2:0]                           rx_sync;    // two sync stages plus edge reference
	logic                                 rx_fall;
	logic                                 byte_stb;
	logic [flash_cmd_pkg::CNT_W-1:0]      byte_cnt;   // bytes stored so far
	logic                                 last_cr;    // previous byte was CR
	logic                                 frame_end;
	logic                                 cnt_full;

	// --------------------
	// rx_int synchroniser and edge strobe
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_sync  <= 3'b000;
			byte_stb <= 1'b0;
		end
		else
		begin
			rx_sync  <= {rx_sync[1:0], rx_int};
			byte_stb <= rx_fall;   // byte taken one cycle later
		end
	end

	assign rx_fall   = ~rx_sync[1] & rx_sync[2];
	assign frame_end = (rx_data == flash_cmd_pkg::CHAR_LF) && last_cr;
	assign cnt_full  = (byte_cnt == flash_cmd_pkg::CNT_W'(flash_cmd_pkg::FRAME_BYTES));

	// --------------------
	// byte counter and framing
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			byte_cnt       <= '0;
			last_cr        <= 1'b0;
			fr.frame_valid <= 1'b0;
			fr.frame_bad   <= 1'b0;
		end
		else
		begin
			fr.frame_valid <= 1'b0;
			fr.frame_bad   <= 1'b0;
			if (byte_stb)
			begin
				if (frame_end)
				begin
					// CR LF must sit at bytes 10 and 11
					if (byte_cnt == flash_cmd_pkg::CNT_W'(flash_cmd_pkg::FRAME_BYTES - 1))
						fr.frame_valid <= 1'b1;
					else
						fr.frame_bad <= 1'b1;
					byte_cnt <= '0;
					last_cr  <= 1'b0;
				end
				else if (cnt_full)
				begin
					fr.frame_bad <= 1'b1;   // thirteenth byte, no ending
					byte_cnt     <= '0;
					last_cr      <= 1'b0;
				end
				else
				begin
					byte_cnt <= byte_cnt + 1'b1;
					last_cr  <= (rx_data == flash_cmd_pkg::CHAR_CR);
				end
			end
		end
	end

	// frame storage, payload only
	always_ff @(posedge clk)
	begin
		if (byte_stb && !cnt_full)
			fr.frame[byte_cnt] <= rx_data;
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		byte_cnt <= flash_cmd_pkg::CNT_W'(flash_cmd_pkg::FRAME_BYTES))
		else $error("frame_assembler: byte counter out of range (%0d)", byte_cnt);

endmodule

/* src/cmd_decoder.sv */
// --------------------
// command decoder
// checks the frame header and maps group and operation
// letters to a flash opcode, address and command type
// --------------------
`timescale 1ns/1ps

module cmd_decoder
(
	input  logic        clk,
	input  logic        rst_n,
	frame_if.decoder    fr,
	flash_req_if.decoder req
);

	flash_cmd_pkg::decode_result_e   dec_result;
	flash_cmd_pkg::flash_op_e        dec_op;
	logic [2:0]                      sr_sel;      // status register select
	logic                            is_recover;
	logic                            hdr_ok;

	assign sr_sel     = fr.frame[6][7:5];
	assign is_recover = (fr.frame[0] == flash_cmd_pkg::REC_R) &&
	                    (fr.frame[1] == flash_cmd_pkg::REC_S);
	assign hdr_ok     = (fr.frame[0] == flash_cmd_pkg::HDR_C) &&
	                    (fr.frame[1] == flash_cmd_pkg::HDR_M) &&
	                    (fr.frame[2] == flash_cmd_pkg::HDR_LEN) &&
	                    (fr.frame[3] == flash_cmd_pkg::HDR_F);

	// --------------------
	// operation mapping
	always_comb
	begin
		dec_op = flash_cmd_pkg::OP_NONE;   // stays none for unknown letters
		if (hdr_ok)
		begin
			case (fr.frame[4])
				flash_cmd_pkg::GRP_R:
					case (fr.frame[5])
						flash_cmd_pkg::OPL_I: dec_op = flash_cmd_pkg::OP_READ_ID;
						flash_cmd_pkg::OPL_S:
							case (sr_sel)
								3'd2:    dec_op = flash_cmd_pkg::OP_READ_SR2;
								3'd3:    dec_op = flash_cmd_pkg::OP_READ_SR3;
								default: dec_op = flash_cmd_pkg::OP_READ_SR1;
							endcase
						default: dec_op = flash_cmd_pkg::OP_NONE;
					endcase
				flash_cmd_pkg::GRP_W:
					case (fr.frame[5])
						flash_cmd_pkg::OPL_E: dec_op = flash_cmd_pkg::OP_WR_ENABLE;
						flash_cmd_pkg::OPL_D: dec_op = flash_cmd_pkg::OP_WR_DISABLE;
						flash_cmd_pkg::OPL_S:
							case (sr_sel)
								3'd1:    dec_op = flash_cmd_pkg::OP_WR_SR1;
								3'd2:    dec_op = flash_cmd_pkg::OP_WR_SR2;
								3'd3:    dec_op = flash_cmd_pkg::OP_WR_SR3;
								default: dec_op = flash_cmd_pkg::OP_NONE;   // no default register on writes
							endcase
						flash_cmd_pkg::OPL_Q: dec_op = flash_cmd_pkg::OP_ENTER_QPI;
						flash_cmd_pkg::OPL_O: dec_op = flash_cmd_pkg::OP_EXIT_QPI;
						default: dec_op = flash_cmd_pkg::OP_NONE;
					endcase
				flash_cmd_pkg::GRP_Q:
					case (fr.frame[5])
						flash_cmd_pkg::OPL_P: dec_op = flash_cmd_pkg::OP_QUAD_PROGRAM;
						flash_cmd_pkg::OPL_R: dec_op = flash_cmd_pkg::OP_QUAD_READ;
						default: dec_op = flash_cmd_pkg::OP_NONE;
					endcase
				flash_cmd_pkg::GRP_S:
					case (fr.frame[5])
						flash_cmd_pkg::OPL_P: dec_op = flash_cmd_pkg::OP_PAGE_PROGRAM;
						flash_cmd_pkg::OPL_R: dec_op = flash_cmd_pkg::OP_READ;
						flash_cmd_pkg::OPL_E: dec_op = flash_cmd_pkg::OP_SECTOR_ERASE;
						default: dec_op = flash_cmd_pkg::OP_NONE;
					endcase
				default: dec_op = flash_cmd_pkg::OP_NONE;
			endcase
		end

		if (is_recover)
			dec_result = flash_cmd_pkg::RES_RECOVER;
		else if (dec_op != flash_cmd_pkg::OP_NONE)
			dec_result = flash_cmd_pkg::RES_ISSUE;
		else
			dec_result = flash_cmd_pkg::RES_INVALID;
	end

	// --------------------
	// request register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			req.req_valid <= 1'b0;
		else
			req.req_valid <= fr.frame_valid | fr.frame_bad;
	end

	always_ff @(posedge clk)
	begin
		if (fr.frame_valid)
		begin
			req.result   <= dec_result;
			req.op       <= dec_op;
			req.cmd_type <= fr.frame[6][4:0];
			req.addr     <= {fr.frame[7], fr.frame[8], fr.frame[9]};   // byte 7 is msb
		end
		else if (fr.frame_bad)
		begin
			req.result   <= flash_cmd_pkg::RES_INVALID;   // length error
			req.op       <= flash_cmd_pkg::OP_NONE;
			req.cmd_type <= '0;
			req.addr     <= '0;
		end
	end

	a_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		req.req_valid |=> !req.req_valid)
		else $error("cmd_decoder: req_valid high on two consecutive cycles");

endmodule

/* src/flash_cmd_issuer.sv */
// --------------------
// flash command issuer
// holds a request on the flash outputs until done, drives the LEDs
// --------------------
`timescale 1ns/1ps

module flash_cmd_issuer
(
	input  logic                        clk,
	input  logic                        rst_n,
	flash_req_if.issuer                 req,
	input  logic                        done,        // pulse from flash controller
	output logic [7:0]                  flash_cmd,
	output flash_cmd_pkg::addr_t        flash_addr,
	output flash_cmd_pkg::cmd_type_t    cmd_type,
	output logic [3:0]                  led
);

	typedef enum logic {ST_IDLE, ST_BUSY} issue_state_e;

	issue_state_e state;

	// --------------------
	// issue FSM
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= ST_IDLE;
			flash_cmd  <= 8'h00;
			flash_addr <= '0;
			cmd_type   <= '0;
			led        <= flash_cmd_pkg::LED_RESET;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (req.req_valid)
					begin
						case (req.result)
							flash_cmd_pkg::RES_ISSUE:
							begin
								flash_cmd  <= req.op;
								flash_addr <= req.addr;
								cmd_type   <= req.cmd_type;
								led        <= flash_cmd_pkg::LED_BUSY;
								state      <= ST_BUSY;
							end
							flash_cmd_pkg::RES_RECOVER: led <= flash_cmd_pkg::LED_RECOVER;
							default:                    led <= flash_cmd_pkg::LED_ERROR;
						endcase
					end
				end
				ST_BUSY:
				begin
					// new requests are dropped here
					if (done)
					begin
						flash_cmd  <= 8'h00;
						flash_addr <= '0;
						cmd_type   <= '0;
						led        <= flash_cmd_pkg::LED_DONE;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_busy_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_BUSY |-> flash_cmd != 8'h00)
		else $error("flash_cmd_issuer: zero opcode while busy");

	a_busy_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_BUSY && !done) |=> $stable(flash_cmd) && $stable(flash_addr))
		else $error("flash_cmd_issuer: request changed while busy");

endmodule

/* src/cmd_process_top.sv */
// --------------------
// serial command processor, top level
// UART bytes in, flash request and status LEDs out
// --------------------
`timescale 1ns/1ps

module cmd_process_top
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         rx_int,       // high during byte reception
	input  logic [7:0]   rx_data,
	input  logic         done,         // flash controller finished
	output logic [7:0]   flash_cmd,
	output logic [23:0]  flash_addr,
	output logic [4:0]   cmd_type,
	output logic [3:0]   led
);

	frame_if     frame_bus ();
	flash_req_if req_bus ();

	// --------------------
	// pipeline stages
	frame_assembler frame_assembler_i
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.rx_int  (rx_int),
		.rx_data (rx_data),
		.fr      (frame_bus.assembler)
	);

	cmd_decoder cmd_decoder_i
	(
		.clk   (clk),
		.rst_n (rst_n),
		.fr    (frame_bus.decoder),
		.req   (req_bus.decoder)
	);

	flash_cmd_issuer flash_cmd_issuer_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req_bus.issuer),
		.done       (done),
		.flash_cmd  (flash_cmd),
		.flash_addr (flash_addr),
		.cmd_type   (cmd_type),
		.led        (led)
	);

endmodule

/* testbench/tb_cmd_process.sv */
// --------------------
// testbench for the serial command processor
// UART byte stimulus, flash controller model and checks
// --------------------
`timescale 1ns/1ps

module tb_cmd_process;

	localparam int N_OPS      = 19;
	localparam int NUM_FRAMES = N_OPS + 9 + 4 + 1 + 2;

	// group, operation, status select (FF = any type byte), expected opcode
	localparam logic [31:0] OP_TABLE [N_OPS] = '{
		{"R", "I", 8'hFF, 8'h90}, {"R", "S", 8'h00, 8'h05}, {"R", "S", 8'h01, 8'h05},
		{"R", "S", 8'h02, 8'h35}, {"R", "S", 8'h03, 8'h15}, {"R", "S", 8'h06, 8'h05},
		{"R", "S", 8'h07, 8'h05}, {"W", "E", 8'hFF, 8'h06}, {"W", "D", 8'hFF, 8'h04},
		{"W", "S", 8'h01, 8'h01}, {"W", "S", 8'h02, 8'h31}, {"W", "S", 8'h03, 8'h11},
		{"W", "Q", 8'hFF, 8'h38}, {"W", "O", 8'hFF, 8'hFF}, {"Q", "P", 8'hFF, 8'h32},
		{"Q", "R", 8'hFF, 8'h6B}, {"S", "P", 8'hFF, 8'h02}, {"S", "R", 8'hFF, 8'h03},
		{"S", "E", 8'hFF, 8'h20}
	};

	logic        clk;
	logic        rst_n;
	logic        rx_int;
	logic [7:0]  rx_data;
	logic        done;
	logic [7:0]  flash_cmd;
	logic [23:0] flash_addr;
	logic [4:0]  cmd_type;
	logic [3:0]  led;

	integer      seed;
	int          errors;
	int          sva_errors;
	int          pass_cnt;
	int          fail_cnt;
	int          err_mark;
	int          done_delay;      // cycles until the model answers
	logic        hold_done;       // keeps the model from answering
	logic [7:0]  early_cmd;       // flash_cmd one cycle before the opcode is due
	string       cur_test;
	logic [7:0]  tx_buf [0:15];

	cmd_process_top cmd_process_top_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_int     (rx_int),
		.rx_data    (rx_data),
		.done       (done),
		.flash_cmd  (flash_cmd),
		.flash_addr (flash_addr),
		.cmd_type   (cmd_type),
		.led        (led)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// flash controller model, one done pulse per command
	initial
	begin
		done <= 1'b0;
		forever
		begin
			@(posedge clk);
			if (rst_n === 1'b1 && flash_cmd != 8'h00)
			begin
				repeat (done_delay - 1) @(posedge clk);
				while (hold_done)
					@(posedge clk);
				done <= 1'b1;
				@(posedge clk);
				done <= 1'b0;
				@(posedge clk);   // outputs clear here
			end
		end
	end

	// request must stay on the outputs until done
	hold_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(flash_cmd != 8'h00 && !done) |=>
		($stable(flash_cmd) && $stable(flash_addr) && $stable(cmd_type) && $stable(led)))
		else
		begin
			$display("error %s: flash outputs or led changed before done", cur_test);
			sva_errors++;
		end

	initial
	begin
		repeat (NUM_FRAMES * 400 + 1000) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", NUM_FRAMES * 400 + 1000);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// --------------------
	// helpers
	task automatic begin_test(input string name);
		cur_test = name;
		err_mark = errors + sva_errors;
	endtask

	task automatic end_test();
		if (errors + sva_errors == err_mark)
		begin
			pass_cnt++;
			$display("pass  %s", cur_test);
		end
		else
		begin
			fail_cnt++;
			$display("fail  %s", cur_test);
		end
	endtask

	task automatic check_val(input string what, input logic [23:0] exp, input logic [23:0] act);
		assert (act === exp)
		else
		begin
			$display("error %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_idle(input logic [3:0] exp_led);
		check_val("flash_cmd", 24'h0, 24'(flash_cmd));
		check_val("flash_addr", 24'h0, flash_addr);
		check_val("cmd_type", 24'h0, 24'(cmd_type));
		check_val("led", 24'(exp_led), 24'(led));
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		rx_int  <= 1'b1;
		rx_data <= b;
		repeat (4) @(posedge clk);
		rx_int <= 1'b0;   // byte taken on this edge
		repeat (4) @(posedge clk);
	endtask

	// sends the first n bytes, then waits out the 5-cycle latency
	task automatic send_buf(input int n);
		for (int i = 0; i < n; i++)
			send_byte(tx_buf[i]);
		@(posedge clk);
		@(negedge clk);
		early_cmd = flash_cmd;   // opcode not due yet
		@(negedge clk);
	endtask

	task automatic build_cmd(input logic [7:0] grp, input logic [7:0] opl,
		input logic [7:0] tbyte, input logic [23:0] addr);
		tx_buf[0]  = "C";
		tx_buf[1]  = "M";
		tx_buf[2]  = 8'h0C;
		tx_buf[3]  = "F";
		tx_buf[4]  = grp;
		tx_buf[5]  = opl;
		tx_buf[6]  = tbyte;
		tx_buf[7]  = addr[23:16];   // msb first
		tx_buf[8]  = addr[15:8];
		tx_buf[9]  = addr[7:0];
		tx_buf[10] = 8'h0D;
		tx_buf[11] = 8'h0A;
	endtask

	function automatic logic crlf_early();
		logic found;
		found = 1'b0;
		for (int i = 0; i < 10; i++)
			if (tx_buf[i] == 8'h0D && tx_buf[i+1] == 8'h0A)
				found = 1'b1;
		return found;
	endfunction

	task automatic wait_done();
		int n;
		n = 0;
		while (done !== 1'b1 && n < 40)
		begin
			@(negedge clk);
			n++;
		end
		if (done !== 1'b1)
		begin
			$display("error %s: no done pulse seen from the flash model", cur_test);
			errors++;
		end
		@(negedge clk);
	endtask

	task automatic issue_entry(input int idx);
		logic [31:0] ent;
		logic [7:0]  tbyte;
		logic [23:0] addr;
		integer      r;
		ent = OP_TABLE[idx];
		begin_test($sformatf("issue %c%c sel %0h", ent[31:24], ent[23:16], ent[15:8]));
		do
		begin
			tbyte = 8'($random(seed));
			addr  = 24'($random(seed));
			if (ent[15:8] != 8'hFF)
				tbyte[7:5] = ent[10:8];
			build_cmd(ent[31:24], ent[23:16], tbyte, addr);
		end
		while (crlf_early());
		r = $random(seed);
		done_delay = 2 + ((r & 32'h7fffffff) % 19);
		send_buf(12);
		check_val("flash_cmd a cycle early", 24'h0, 24'(early_cmd));
		check_val("flash_cmd", 24'(ent[7:0]), 24'(flash_cmd));
		check_val("flash_addr", addr, flash_addr);
		check_val("cmd_type", 24'(tbyte[4:0]), 24'(cmd_type));
		check_val("led", 24'(flash_cmd_pkg::LED_BUSY), 24'(led));
		wait_done();
		check_idle(flash_cmd_pkg::LED_DONE);
		end_test();
	endtask

	task automatic expect_led(input string name, input int n, input logic [3:0] exp_led);
		begin_test(name);
		send_buf(n);
		check_val("led", 24'(exp_led), 24'(led));
		check_val("flash_cmd", 24'h0, 24'(flash_cmd));
		end_test();
	endtask

	// --------------------
	// test sequence
	initial
	begin
		seed       = 32'h174f6ea2;
		hold_done  = 1'b0;
		done_delay = 2;
		cur_test   = "reset values";
		rst_n   <= 1'b0;
		rx_int  <= 1'b0;
		rx_data <= 8'h00;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		begin_test("reset values");
		check_idle(flash_cmd_pkg::LED_RESET);
		end_test();

		for (int i = 0; i < N_OPS; i++)
			issue_entry(i);

		build_cmd("R", "I", 8'h20, 24'h123456);
		tx_buf[1] = "X";
		expect_led("bad header byte", 12, flash_cmd_pkg::LED_ERROR);
		build_cmd("R", "I", 8'h20, 24'h123456);
		tx_buf[2] = 8'h0B;
		expect_led("bad length byte", 12, flash_cmd_pkg::LED_ERROR);
		build_cmd("R", "X", 8'h20, 24'h123456);
		expect_led("unknown operation", 12, flash_cmd_pkg::LED_ERROR);
		build_cmd("Z", "P", 8'h20, 24'h123456);
		expect_led("unknown group", 12, flash_cmd_pkg::LED_ERROR);
		build_cmd("W", "S", 8'h05, 24'h123456);
		expect_led("write status select 0", 12, flash_cmd_pkg::LED_ERROR);
		for (int s = 4; s < 8; s++)
		begin
			build_cmd("W", "S", {s[2:0], 5'h09}, 24'h123456);
			expect_led($sformatf("write status select %0d", s), 12, flash_cmd_pkg::LED_ERROR);
		end

		for (int i = 2; i < 10; i++)
			tx_buf[i] = 8'h00;
		tx_buf[0]  = "R";
		tx_buf[1]  = "S";
		tx_buf[10] = 8'h0D;
		tx_buf[11] = 8'h0A;
		expect_led("recover frame", 12, flash_cmd_pkg::LED_RECOVER);

		build_cmd("R", "I", 8'h0D, 24'h0A0000);   // CR LF at bytes 6 and 7
		expect_led("early CR LF", 8, flash_cmd_pkg::LED_ERROR);
		issue_entry(17);
		for (int i = 0; i < 13; i++)
			tx_buf[i] = 8'h55;
		expect_led("thirteen bytes without ending", 13, flash_cmd_pkg::LED_ERROR);
		issue_entry(0);

		// second frame arrives while the first is outstanding
		begin_test("frame while busy");
		hold_done = 1'b1;
		build_cmd("S", "P", 8'h07, 24'h3C5A96);
		send_buf(12);
		check_val("flash_cmd", 24'h02, 24'(flash_cmd));
		check_val("led", 24'(flash_cmd_pkg::LED_BUSY), 24'(led));
		build_cmd("Q", "R", 8'h1F, 24'h123456);
		send_buf(12);
		check_val("flash_cmd", 24'h02, 24'(flash_cmd));
		check_val("flash_addr", 24'h3C5A96, flash_addr);
		check_val("led", 24'(flash_cmd_pkg::LED_BUSY), 24'(led));
		hold_done = 1'b0;
		wait_done();
		check_idle(flash_cmd_pkg::LED_DONE);
		end_test();

		$display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt,
			errors + sva_errors);
		if (fail_cnt == 0 && errors + sva_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
src/flash_cmd_pkg.sv
src/frame_if.sv
src/flash_req_if.sv
src/frame_assembler.sv
src/cmd_decoder.sv
src/flash_cmd_issuer.sv
src/cmd_process_top.sv
testbench/tb_cmd_process.sv

/* Makefile */
# Verilator build and run for the serial command processor

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_cmd_process
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
